/* design/decode_steer.sv */
`default_nettype none
`include "fetch_config.svh"

module decode_steer
	import fetch_pkg::*;
(
	input  wire            clk,
	input  wire            rst_n_i,
	input  wire            flush_i,
	input  wire            decode_ready_i,
	input  wire            push_i,
	input  wire [`FETCH_WIDTH-1:0] lane_empty_i,
	input  wire fetch_pc_t lane_pc_i [`FETCH_WIDTH],
	input  wire insn_t     lane_insn_i [`FETCH_WIDTH],
	output logic [`FETCH_WIDTH-1:0] lane_pop_o,
	output logic           decode_valid_o,
	output fetch_pc_t      decode_pc_o,
	output insn_t          decode_insn_o
);

	// keep at least one bit even for a single lane
	localparam int unsigned SEL_BITS = (`FETCH_WIDTH > 1) ? $clog2(`FETCH_WIDTH) : 1;
	localparam logic [SEL_BITS-1:0] LAST_LANE = SEL_BITS'(`FETCH_WIDTH - 1);

	logic [SEL_BITS-1:0] sel_q;
	logic cur_empty;
	logic xfer;

	// sel_q points at the lane with the oldest instruction
	assign cur_empty = lane_empty_i[sel_q];

	// an empty lane can still offer the group arriving this cycle
	assign decode_valid_o = !cur_empty || push_i;
	assign decode_pc_o = lane_pc_i[sel_q];
	assign decode_insn_o = lane_insn_i[sel_q];

	assign xfer = decode_valid_o && decode_ready_i;

	// one-hot pop of the selected lane
	always_comb begin
		lane_pop_o = '0;
		if (xfer) begin
			lane_pop_o[sel_q] = 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i || flush_i) begin
			sel_q <= '0;
		end else if (xfer) begin
			if (sel_q == LAST_LANE) begin
				sel_q <= '0;
			end else begin
				sel_q <= sel_q + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* design/fetch_config.svh */
`ifndef FETCH_CONFIG_SVH
`define FETCH_CONFIG_SVH

// instructions per fetch group, also the number of buffer lanes
`define FETCH_WIDTH 2

// entries held by each lane
`define IFB_DEPTH 4

// lane pointer width, log2 of the depth
`define IFB_PTR_BITS 2

// first fetch address out of reset
`define RESET_PC 64'h0000_0000_0000_0000

`endif

/* design/fetch_frontend.sv */
`default_nettype none
`include "fetch_config.svh"

module fetch_frontend
	import fetch_pkg::*;
(
	input  wire               clk,
	input  wire               rst_n_i,
	input  wire               flush_i,
	input  wire fetch_pc_t    redirect_pc_i,
	output fetch_pc_t         imem_addr_o,
	input  wire fetch_group_t imem_group_i,
	input  wire               decode_ready_i,
	output logic              decode_valid_o,
	output fetch_pc_t         decode_pc_o,
	output insn_t             decode_insn_o
);

	wire push;
	wire fetch_pc_t group_pc;

	wire [`FETCH_WIDTH-1:0] lane_full;
	wire [`FETCH_WIDTH-1:0] lane_empty;
	wire [`FETCH_WIDTH-1:0] lane_pop;
	wire fetch_pc_t lane_pc [`FETCH_WIDTH];
	wire insn_t lane_insn [`FETCH_WIDTH];

	fetch_pc_gen u_pc_gen (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.flush_i       (flush_i),
		.redirect_pc_i (redirect_pc_i),
		.lane_full_i   (lane_full),
		.imem_addr_o   (imem_addr_o),
		.push_o        (push),
		.group_pc_o    (group_pc)
	);

	// lane k takes slot k of every group
	for (genvar k = 0; k < `FETCH_WIDTH; k++) begin : g_lane
		wire fetch_pc_t slot_pc_w;
		wire insn_t slot_insn_w;

		assign slot_pc_w = slot_pc(group_pc, k);
		assign slot_insn_w = group_slot(imem_group_i, k);

		insn_fetch_buffer u_ifb (
			.clk     (clk),
			.rst_n_i (rst_n_i),
			.flush_i (flush_i),
			.push_i  (push),
			.pc_i    (slot_pc_w),
			.insn_i  (slot_insn_w),
			.pop_i   (lane_pop[k]),
			.full_o  (lane_full[k]),
			.empty_o (lane_empty[k]),
			.pc_o    (lane_pc[k]),
			.insn_o  (lane_insn[k])
		);
	end

	decode_steer u_steer (
		.clk            (clk),
		.rst_n_i        (rst_n_i),
		.flush_i        (flush_i),
		.decode_ready_i (decode_ready_i),
		.push_i         (push),
		.lane_empty_i   (lane_empty),
		.lane_pc_i      (lane_pc),
		.lane_insn_i    (lane_insn),
		.lane_pop_o     (lane_pop),
		.decode_valid_o (decode_valid_o),
		.decode_pc_o    (decode_pc_o),
		.decode_insn_o  (decode_insn_o)
	);

endmodule

`default_nettype wire

/* design/fetch_pc_gen.sv */
`default_nettype none
`include "fetch_config.svh"

module fetch_pc_gen
	import fetch_pkg::*;
(
	input  wire            clk,
	input  wire            rst_n_i,
	input  wire            flush_i,
	input  wire fetch_pc_t redirect_pc_i,
	input  wire [`FETCH_WIDTH-1:0] lane_full_i,
	output fetch_pc_t      imem_addr_o,
	output logic           push_o,
	output fetch_pc_t      group_pc_o
);

	fetch_pc_t pc_q;
	fetch_pc_t pc_d;
	logic fetch_en_q;
	logic stall;

	// lanes fill together, so one full lane blocks the group
	assign stall = |lane_full_i;

	// first cycle out of reset only presents the address
	assign push_o = fetch_en_q && !stall && !flush_i;

	// the memory sees the group address, lanes get the same base
	assign imem_addr_o = pc_q;
	assign group_pc_o = pc_q;

	always_comb begin
		pc_d = pc_q;
		if (flush_i) begin
			// redirect wins over any push, current group dropped
			pc_d = group_align(redirect_pc_i);
		end else if (push_o) begin
			pc_d = group_next(pc_q);
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			pc_q <= group_align(`RESET_PC);
			fetch_en_q <= 1'b0;
		end else begin
			pc_q <= pc_d;
			fetch_en_q <= 1'b1;
		end
	end

endmodule

`default_nettype wire

/* design/fetch_pkg.sv */
`default_nettype none
`include "fetch_config.svh"

package fetch_pkg;

	typedef logic [63:0] fetch_pc_t;
	typedef logic [31:0] insn_t;

	// slot 0 in the low bits
	typedef logic [`FETCH_WIDTH*32-1:0] fetch_group_t;

	localparam int unsigned GROUP_BYTES = 4 * `FETCH_WIDTH;
	localparam int unsigned GROUP_OFFSET_BITS = $clog2(GROUP_BYTES);

	// clear the byte offset inside a group
	function automatic fetch_pc_t group_align(input fetch_pc_t pc);
		fetch_pc_t mask;
		mask = ~((fetch_pc_t'(1) << GROUP_OFFSET_BITS) - fetch_pc_t'(1));
		return pc & mask;
	endfunction

	function automatic fetch_pc_t group_next(input fetch_pc_t pc);
		return pc + fetch_pc_t'(GROUP_BYTES);
	endfunction

	// address of one instruction slot within a group
	function automatic fetch_pc_t slot_pc(input fetch_pc_t group_pc, input int unsigned slot);
		return group_pc + fetch_pc_t'(4 * slot);
	endfunction

	function automatic insn_t group_slot(input fetch_group_t grp, input int unsigned slot);
		return grp[slot*32 +: 32];
	endfunction

endpackage

`default_nettype wire

/* design/insn_fetch_buffer.sv */
`default_nettype none
`include "fetch_config.svh"

module insn_fetch_buffer
	import fetch_pkg::*;
(
	input  wire            clk,
	input  wire            rst_n_i,
	input  wire            flush_i,
	input  wire            push_i,
	input  wire fetch_pc_t pc_i,
	input  wire insn_t     insn_i,
	input  wire            pop_i,
	output logic           full_o,
	output logic           empty_o,
	output fetch_pc_t      pc_o,
	output insn_t          insn_o
);

	localparam logic [`IFB_PTR_BITS-1:0] LAST_IDX = `IFB_PTR_BITS'(`IFB_DEPTH - 1);

	fetch_pc_t pc_mem [`IFB_DEPTH];
	insn_t insn_mem [`IFB_DEPTH];

	logic [`IFB_PTR_BITS-1:0] head_q;
	logic [`IFB_PTR_BITS-1:0] tail_q;
	logic head_wrap_q;
	logic tail_wrap_q;

	logic bypass;
	logic wr_en;
	logic rd_en;

	// same slot on both pointers, wrap bits tell empty from full
	assign empty_o = (head_q == tail_q) && (head_wrap_q == tail_wrap_q);
	assign full_o = (head_q == tail_q) && (head_wrap_q != tail_wrap_q);

	// empty lane hands the incoming word straight to decode
	assign bypass = empty_o && push_i && pop_i;

	assign wr_en = push_i && !full_o && !bypass;
	assign rd_en = pop_i && !empty_o;

	// when empty the output shows the incoming slot, so valid data
	// is there before the pop decision is made
	assign pc_o = empty_o ? pc_i : pc_mem[head_q];
	assign insn_o = empty_o ? insn_i : insn_mem[head_q];

	// pointer and wrap state
	always_ff @(posedge clk) begin
		if (!rst_n_i || flush_i) begin
			head_q <= '0;
			tail_q <= '0;
			head_wrap_q <= 1'b0;
			tail_wrap_q <= 1'b0;
		end else begin
			if (wr_en) begin
				if (tail_q == LAST_IDX) begin
					tail_q <= '0;
					tail_wrap_q <= ~tail_wrap_q;
				end else begin
					tail_q <= tail_q + 1'b1;
				end
			end
			if (rd_en) begin
				if (head_q == LAST_IDX) begin
					head_q <= '0;
					head_wrap_q <= ~head_wrap_q;
				end else begin
					head_q <= head_q + 1'b1;
				end
			end
		end
	end

	// entry storage
	always_ff @(posedge clk) begin
		if (wr_en) begin
			pc_mem[tail_q] <= pc_i;
			insn_mem[tail_q] <= insn_i;
		end
	end

endmodule

`default_nettype wire

/* fetch_frontend.f */
+incdir+design
design/fetch_pkg.sv
design/fetch_pc_gen.sv
design/insn_fetch_buffer.sv
design/decode_steer.sv
design/fetch_frontend.sv
tb/tb_fetch_frontend.sv

/* run_sim.sh */
#!/bin/sh
# compile and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -Wno-fatal \
	-f fetch_frontend.f \
	--top-module tb_fetch_frontend \
	-Mdir obj_dir

./obj_dir/Vtb_fetch_frontend 2>&1 | tee sim.log

if grep -qx "Regression passed" sim.log; then
	echo "simulation passed"
else
	echo "simulation failed, see sim.log"
	exit 1
fi

/* tb/tb_fetch_frontend.sv */
`default_nettype none
`include "fetch_config.svh"

module tb_fetch_frontend
	import fetch_pkg::*;
();

	localparam int unsigned CLK_HALF = 20;
	localparam int unsigned RESET_CYCLES = 3;
	localparam int unsigned GRP_BYTES = 4 * `FETCH_WIDTH;
	localparam logic [31:0] INSN_KEY = 32'h3c5a_0013;

	// cycle budget of each test summed into the timeout
	localparam int unsigned STREAM_BUDGET = 40;
	localparam int unsigned STALL_BUDGET = 50;
	localparam int unsigned RANDOM_LEN = 300;
	localparam int unsigned RANDOM_BUDGET = RANDOM_LEN + 10;
	localparam int unsigned FLUSH_FULL_BUDGET = 50;
	localparam int unsigned FLUSH_ALIGN_BUDGET = 40;
	localparam int unsigned MID_RESET_BUDGET = 40;
	localparam int unsigned TIMEOUT_CYCLES = RESET_CYCLES + STREAM_BUDGET + STALL_BUDGET
		+ RANDOM_BUDGET + FLUSH_FULL_BUDGET + FLUSH_ALIGN_BUDGET + MID_RESET_BUDGET + 100;

	logic clk = 1'b0;
	logic rst_n;
	logic flush;
	fetch_pc_t redirect_pc;
	logic decode_ready;
	fetch_pc_t imem_addr;
	wire fetch_group_t imem_group;
	logic decode_valid;
	fetch_pc_t decode_pc;
	insn_t decode_insn;

	// expected program order plus a lane occupancy model
	fetch_pc_t exp_q [$];
	fetch_pc_t m_pc;
	logic m_en;
	logic m_full;
	int unsigned m_cnt [`FETCH_WIDTH];
	int unsigned m_sel;

	int unsigned cycle_count;
	int unsigned xfer_count;
	int unsigned err_count;
	fetch_pc_t last_xfer_pc;

	always #(CLK_HALF) clk = ~clk;

	fetch_frontend dut (
		.clk            (clk),
		.rst_n_i        (rst_n),
		.flush_i        (flush),
		.redirect_pc_i  (redirect_pc),
		.imem_addr_o    (imem_addr),
		.imem_group_i   (imem_group),
		.decode_ready_i (decode_ready),
		.decode_valid_o (decode_valid),
		.decode_pc_o    (decode_pc),
		.decode_insn_o  (decode_insn)
	);

	// every word carries its own address under a fixed key
	function automatic insn_t insn_for(input fetch_pc_t pc);
		return pc[31:0] ^ INSN_KEY;
	endfunction

	function automatic fetch_pc_t align_pc(input fetch_pc_t pc);
		return pc & ~fetch_pc_t'(GRP_BYTES - 1);
	endfunction

	// combinational instruction memory
	for (genvar k = 0; k < `FETCH_WIDTH; k++) begin : g_mem
		assign imem_group[k*32 +: 32] = insn_for(imem_addr + 64'(4 * k));
	end

	task automatic stop_with_failure(input string why);
		err_count++;
		$display("%s", why);
		$display("Regression failed");
		$fatal(1, "run stopped");
	endtask

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] expected);
		if (got !== expected) begin
			err_count++;
			$display("Fail at time %0t: %s is %h, expected %h", $time, name, got, expected);
			$display("Regression failed");
			$fatal(1, "first mismatch");
		end
	endtask

	// one cycle of the reference model run mid-cycle once all signals settle
	task automatic step_model();
		logic full_any;
		logic push;
		logic valid;
		logic xfer;
		logic pop_k;
		logic bypass_k;
		int unsigned old_cnt;
		int unsigned k;
		fetch_pc_t exp_pc;
		cycle_count++;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			stop_with_failure("Timeout: the tests did not finish within the cycle limit");
		end else if (!rst_n) begin
			m_pc = align_pc(`RESET_PC);
			m_en = 1'b0;
			m_sel = 0;
			m_full = 1'b0;
			for (k = 0; k < `FETCH_WIDTH; k++) begin
				m_cnt[k] = 0;
			end
			exp_q.delete();
		end else begin
			full_any = 1'b0;
			for (k = 0; k < `FETCH_WIDTH; k++) begin
				if (m_cnt[k] == `IFB_DEPTH) begin
					full_any = 1'b1;
				end
			end
			// whole group goes in when nothing is full and no flush
			push = m_en && !full_any && !flush;
			if (push) begin
				for (k = 0; k < `FETCH_WIDTH; k++) begin
					exp_q.push_back(m_pc + 64'(4 * k));
				end
			end
			valid = (m_cnt[m_sel] != 0) || push;
			xfer = valid && decode_ready;

			check_value("imem_addr_o", imem_addr, m_pc);
			check_value("decode_valid_o", 64'(decode_valid), 64'(valid));
			if (xfer) begin
				exp_pc = exp_q.pop_front();
				check_value("decode_pc_o", decode_pc, exp_pc);
				check_value("decode_insn_o", 64'(decode_insn), 64'(insn_for(exp_pc)));
				last_xfer_pc = decode_pc;
				xfer_count++;
			end

			for (k = 0; k < `FETCH_WIDTH; k++) begin
				old_cnt = m_cnt[k];
				pop_k = xfer && (m_sel == k);
				// empty lane popped during its push passes the word through
				bypass_k = (old_cnt == 0) && push && pop_k;
				if (push && !bypass_k) begin
					m_cnt[k]++;
				end
				if (pop_k && old_cnt != 0) begin
					m_cnt[k]--;
				end
			end
			if (xfer) begin
				m_sel = (m_sel + 1) % `FETCH_WIDTH;
			end

			if (flush) begin
				m_pc = align_pc(redirect_pc);
				m_sel = 0;
				exp_q.delete();
				for (k = 0; k < `FETCH_WIDTH; k++) begin
					m_cnt[k] = 0;
				end
			end else if (push) begin
				m_pc = m_pc + 64'(GRP_BYTES);
			end
			m_en = 1'b1;

			m_full = 1'b0;
			for (k = 0; k < `FETCH_WIDTH; k++) begin
				if (m_cnt[k] == `IFB_DEPTH) begin
					m_full = 1'b1;
				end
			end
		end
	endtask

	always @(negedge clk) begin
		#(CLK_HALF / 2);
		step_model();
	end

	task automatic apply_reset();
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		rst_n = 1'b1;
	endtask

	task automatic wait_for_xfers(input int unsigned target);
		while (xfer_count < target) begin
			@(negedge clk);
		end
	endtask

	task automatic stream_with_ready();
		int unsigned start;
		int unsigned n;
		start = xfer_count;
		decode_ready = 1'b1;
		wait_for_xfers(start + 1);
		check_value("first decode_pc_o", last_xfer_pc, align_pc(`RESET_PC));
		// one instruction per cycle from then on
		for (n = 0; n < 16; n++) begin
			@(negedge clk);
			check_value("transfer count", 64'(xfer_count), 64'(start + 2 + n));
		end
	endtask

	task automatic stall_and_drain();
		fetch_pc_t base;
		fetch_pc_t held;
		int unsigned start;
		base = 64'h0000_0000_0000_1000;
		held = base + 64'(`IFB_DEPTH * GRP_BYTES);
		@(negedge clk);
		// start from empty lanes
		decode_ready = 1'b0;
		flush = 1'b1;
		redirect_pc = base;
		@(negedge clk);
		flush = 1'b0;
		redirect_pc = '0;
		start = xfer_count;
		repeat (`IFB_DEPTH + 2) @(negedge clk);
		check_value("imem_addr_o when full", imem_addr, held);
		check_value("decode_valid_o when full", 64'(decode_valid), 64'(1));
		repeat (4) begin
			@(negedge clk);
			check_value("imem_addr_o during stall", imem_addr, held);
		end
		decode_ready = 1'b1;
		wait_for_xfers(start + `IFB_DEPTH * `FETCH_WIDTH);
		check_value("last buffered decode_pc_o", last_xfer_pc, held - 64'd4);
	endtask

	task automatic random_ready_traffic();
		int unsigned start;
		@(negedge clk);
		start = xfer_count;
		repeat (RANDOM_LEN) begin
			decode_ready = ($urandom() & 32'd1) != 0;
			@(negedge clk);
		end
		if (xfer_count == start) begin
			stop_with_failure("No instruction reached decode under random ready");
		end
	endtask

	task automatic flush_when_full();
		fetch_pc_t target;
		int unsigned start;
		target = 64'h0000_0000_0000_2000;
		@(negedge clk);
		decode_ready = 1'b0;
		while (!m_full) begin
			@(negedge clk);
		end
		flush = 1'b1;
		redirect_pc = target;
		@(negedge clk);
		flush = 1'b0;
		redirect_pc = '0;
		decode_ready = 1'b1;
		start = xfer_count;
		wait_for_xfers(start + 1);
		check_value("decode_pc_o after flush", last_xfer_pc, target);
		wait_for_xfers(start + 12);
		check_value("decode_pc_o order after flush", last_xfer_pc, target + 64'd44);
	endtask

	task automatic flush_unaligned_target();
		fetch_pc_t target;
		fetch_pc_t aligned;
		int unsigned start;
		target = 64'h0000_0000_0000_3006;
		aligned = align_pc(target);
		@(negedge clk);
		decode_ready = 1'b1;
		repeat (5) @(negedge clk);
		flush = 1'b1;
		redirect_pc = target;
		@(negedge clk);
		flush = 1'b0;
		redirect_pc = '0;
		check_value("imem_addr_o after redirect", imem_addr, aligned);
		start = xfer_count;
		wait_for_xfers(start + 1);
		check_value("decode_pc_o after redirect", last_xfer_pc, aligned);
		wait_for_xfers(start + 8);
	endtask

	task automatic reset_mid_stream();
		int unsigned start;
		@(negedge clk);
		decode_ready = 1'b1;
		start = xfer_count;
		wait_for_xfers(start + 5);
		apply_reset();
		#(CLK_HALF / 2);
		check_value("decode_valid_o after reset", 64'(decode_valid), 64'(0));
		check_value("imem_addr_o after reset", imem_addr, align_pc(`RESET_PC));
		@(negedge clk);
		start = xfer_count;
		wait_for_xfers(start + 1);
		check_value("decode_pc_o after reset", last_xfer_pc, align_pc(`RESET_PC));
		wait_for_xfers(start + 6);
	endtask

	initial begin
		void'($urandom(27));
		rst_n = 1'b0;
		flush = 1'b0;
		redirect_pc = '0;
		decode_ready = 1'b0;
		cycle_count = 0;
		xfer_count = 0;
		err_count = 0;
		last_xfer_pc = '0;
		m_full = 1'b0;

		apply_reset();
		stream_with_ready();
		stall_and_drain();
		random_ready_traffic();
		flush_when_full();
		flush_unaligned_target();
		reset_mid_stream();

		if (err_count == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule

`default_nettype wire
